// File: hw/neuron_consts.svh
// Neuron sizing macros: input count, data and fraction widths, weight row count, address width
`ifndef NEURON_CONSTS_SVH
`define NEURON_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Vector size
//////////////////////////////////////////////////////////////////////

// Inputs and weights per neuron
`define NEURON_NUM_IN 4

//////////////////////////////////////////////////////////////////////
// Number format, signed Q8.8
//////////////////////////////////////////////////////////////////////

`define NEURON_DATA_W 16
`define NEURON_FRAC_W 8

//////////////////////////////////////////////////////////////////////
// Weight bank geometry
//////////////////////////////////////////////////////////////////////

`define NEURON_ROWS   8
// Must cover NEURON_ROWS
`define NEURON_ADDR_W 3

`endif

// File: hw/neuron_pkg.sv
// Neuron data types: Q8.8 value, vectors, weight row and the per-stage pipeline structs
`default_nettype none

`include "neuron_consts.svh"

package neuron_pkg;

	// One signed Q8.8 value
	typedef logic signed [`NEURON_DATA_W-1:0] data_t;

	// Input vector or weight vector
	typedef data_t [`NEURON_NUM_IN-1:0] vec_t;

	// One row of the weight bank
	typedef struct packed {
		vec_t  weights;
		data_t bias;
	} weight_row_t;

	// Exact Q16.16 product of two Q8.8 values
	typedef logic signed [2*`NEURON_DATA_W-1:0] prod_t;

	// Bank output, row fetched together with the inputs
	typedef struct packed {
		logic        valid;
		vec_t        inputs;
		weight_row_t row;
	} fetch_t;

	// Product stage output
	typedef struct packed {
		logic                        valid;
		prod_t [`NEURON_NUM_IN-1:0] prods;
		weight_row_t                 row;
	} prod_stage_t;

	// Sum stage output, sum already saturated to Q8.8
	typedef struct packed {
		logic        valid;
		data_t       sum;
		weight_row_t row;
	} sum_stage_t;

endpackage

`default_nettype wire

// File: hw/weight_bank.sv
// Weight bank: row storage with reset clear, write port and registered row fetch stage
`default_nettype none
`timescale 1ns/1ps

`include "neuron_consts.svh"

module weight_bank import neuron_pkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rst,
	// Row write port
	input  wire logic                      i_wr,
	input  wire logic [`NEURON_ADDR_W-1:0] i_wr_addr,
	input  wire weight_row_t               i_wr_row,
	// Compute request
	input  wire logic                      i_valid,
	input  wire logic [`NEURON_ADDR_W-1:0] i_rd_addr,
	input  wire vec_t                      i_inputs,
	// First pipeline stage
	output fetch_t                         o_fetch
);

	// Row storage
	weight_row_t rows [`NEURON_ROWS];

	// Fetch stage registers
	logic        fetch_valid;
	vec_t        fetch_inputs;
	weight_row_t fetch_row;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Bank starts all zero, a write lands on the sampling edge
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < `NEURON_ROWS; r++)
				rows[r] <= '0;
		end
		else if (i_wr)
		begin
			rows[i_wr_addr] <= i_wr_row;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= i_valid;
	end

	// Read of the old contents, so a same-edge write is not seen here
	always_ff @(posedge clk)
	begin
		fetch_inputs <= i_inputs;
		fetch_row    <= rows[i_rd_addr];
	end

	assign o_fetch = '{valid: fetch_valid, inputs: fetch_inputs, row: fetch_row};

endmodule

`default_nettype wire

// File: hw/product_stage.sv
// Product stage: parallel signed multiply of inputs by row weights, row carried alongside
`default_nettype none
`timescale 1ns/1ps

`include "neuron_consts.svh"

module product_stage import neuron_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst,
	// From the weight bank
	input  wire fetch_t i_fetch,
	// To the sum stage
	output prod_stage_t o_prod
);

	// Stage registers
	logic                        prod_valid;
	prod_t [`NEURON_NUM_IN-1:0] prod_vals;
	weight_row_t                 prod_row;

	//////////////////////////////////////////////////////////////////////
	// Valid pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			prod_valid <= 1'b0;
		else
			prod_valid <= i_fetch.valid;
	end

	//////////////////////////////////////////////////////////////////////
	// Multipliers
	//////////////////////////////////////////////////////////////////////

	// One multiplier per input
	// Operands widened first so the Q16.16 product is exact
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `NEURON_NUM_IN; i++)
		begin
			prod_vals[i] <= prod_t'(i_fetch.inputs[i]) * prod_t'(i_fetch.row.weights[i]);
		end
		// Row rides along for the backward pass
		prod_row <= i_fetch.row;
	end

	assign o_prod = '{valid: prod_valid, prods: prod_vals, row: prod_row};

endmodule

`default_nettype wire

// File: hw/sum_stage.sv
// Sum stage module with an adder tree over the products, bias add, rescale and Q8.8 saturation
`default_nettype none
`timescale 1ns/1ps

`include "neuron_consts.svh"

module sum_stage import neuron_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst,
	// From the product stage
	input  wire prod_stage_t i_prod,
	// To the sigmoid stage
	output sum_stage_t       o_sum
);

	// Tree depth and an accumulator wide enough for every carry plus the bias
	localparam int LVLS  = $clog2(`NEURON_NUM_IN);
	localparam int ACC_W = 2*`NEURON_DATA_W + LVLS + 1;

	typedef logic signed [ACC_W-1:0] acc_t;

	// Q8.8 clamp limits at accumulator width
	localparam acc_t SAT_MAX = acc_t'(2**(`NEURON_DATA_W-1) - 1);
	localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

	acc_t        tree [LVLS+1][2**LVLS];
	acc_t        total;
	acc_t        scaled;
	data_t       sat;
	logic        sum_valid;
	data_t       sum_val;
	weight_row_t sum_row;

	//////////////////////////////////////////////////////////////////////
	// Adder tree and rescale
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Slots past the last input stay zero and pad the tree to a power of two
		tree = '{default: '0};
		for (int i = 0; i < `NEURON_NUM_IN; i++)
			tree[0][i] = acc_t'(i_prod.prods[i]);
		for (int l = 1; l <= LVLS; l++)
		begin
			for (int i = 0; i < (2**LVLS >> l); i++)
				tree[l][i] = tree[l-1][2*i] + tree[l-1][2*i+1];
		end
		// Bias moved up to Q16.16 before the add
		total  = tree[LVLS][0] + (acc_t'(i_prod.row.bias) <<< `NEURON_FRAC_W);
		// Arithmetic shift truncates toward minus infinity
		scaled = total >>> `NEURON_FRAC_W;
		if (scaled > SAT_MAX)
			sat = data_t'(SAT_MAX);
		else if (scaled < SAT_MIN)
			sat = data_t'(SAT_MIN);
		else
			sat = data_t'(scaled);
	end

	//////////////////////////////////////////////////////////////////////
	// Stage registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			sum_valid <= 1'b0;
		else
			sum_valid <= i_prod.valid;
	end

	always_ff @(posedge clk)
	begin
		sum_val <= sat;
		sum_row <= i_prod.row;
	end

	assign o_sum = '{valid: sum_valid, sum: sum_val, row: sum_row};

endmodule

`default_nettype wire

// File: hw/sigmoid_pla.sv
// Sigmoid stage: piecewise-linear activation from the Q8.8 sum, with sum and row passed out
`default_nettype none
`timescale 1ns/1ps

`include "neuron_consts.svh"

module sigmoid_pla import neuron_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	// From the sum stage
	input  wire sum_stage_t i_sum,
	// Result and backward-pass taps
	output logic            o_valid,
	output data_t           o_act,
	output data_t           o_sum,
	output weight_row_t     o_row
);

	// Segment breakpoints and offsets, raw Q8.8
	localparam logic [`NEURON_DATA_W-1:0] ONE     = 16'd256;
	localparam logic [`NEURON_DATA_W-1:0] BRK_MID = 16'd608;  // 2.375
	localparam logic [`NEURON_DATA_W-1:0] BRK_TOP = 16'd1280; // 5.0
	localparam logic [`NEURON_DATA_W-1:0] OFS_LOW = 16'd128;  // 0.5
	localparam logic [`NEURON_DATA_W-1:0] OFS_MID = 16'd160;  // 0.625
	localparam logic [`NEURON_DATA_W-1:0] OFS_HI  = 16'd216;  // 0.84375

	logic [`NEURON_DATA_W-1:0] mag;
	logic [`NEURON_DATA_W-1:0] slope;
	logic [`NEURON_DATA_W-1:0] offset;
	logic [`NEURON_DATA_W-1:0] half_act;
	data_t                     act;

	//////////////////////////////////////////////////////////////////////
	// Segment select
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Absolute value, most negative sum pinned to the largest magnitude
		if (i_sum.sum == data_t'(16'h8000))
			mag = 16'h7fff;
		else if (i_sum.sum < 0)
			mag = 16'(-i_sum.sum);
		else
			mag = 16'(i_sum.sum);

		// Slope as a truncating shift, offset per segment
		if (mag >= BRK_TOP)
		begin
			slope  = '0;
			offset = ONE;
		end
		else if (mag >= BRK_MID)
		begin
			slope  = mag >> 5;
			offset = OFS_HI;
		end
		else if (mag >= ONE)
		begin
			slope  = mag >> 3;
			offset = OFS_MID;
		end
		else
		begin
			slope  = mag >> 2;
			offset = OFS_LOW;
		end
		half_act = slope + offset;

		// Mirror about 0.5 for negative sums
		act = (i_sum.sum < 0) ? data_t'(ONE - half_act) : data_t'(half_act);
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			o_valid <= 1'b0;
		else
			o_valid <= i_sum.valid;
	end

	// Sum and row leave with the activation for the backward pass
	always_ff @(posedge clk)
	begin
		o_act <= act;
		o_sum <= i_sum.sum;
		o_row <= i_sum.row;
	end

endmodule

`default_nettype wire

// File: hw/sigmoid_neuron.sv
// Sigmoid neuron top: weight bank, product, sum and sigmoid stages in a four-cycle pipeline
`default_nettype none
`timescale 1ns/1ps

`include "neuron_consts.svh"

module sigmoid_neuron import neuron_pkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rst,
	// Weight row write
	input  wire logic                      i_wr,
	input  wire logic [`NEURON_ADDR_W-1:0] i_wr_addr,
	input  wire weight_row_t               i_wr_row,
	// Compute request
	input  wire logic                      i_valid,
	input  wire logic [`NEURON_ADDR_W-1:0] i_rd_addr,
	input  wire vec_t                      i_inputs,
	// Result, four edges after the request
	output logic                           o_valid,
	output data_t                          o_act,
	output data_t                          o_sum,
	output weight_row_t                    o_row
);

	// Stage to stage
	fetch_t      fetch;
	prod_stage_t prod;
	sum_stage_t  sum;

	// Stage 1, row fetch
	weight_bank i_weight_bank (
		.clk      (clk),
		.rst      (rst),
		.i_wr     (i_wr),
		.i_wr_addr(i_wr_addr),
		.i_wr_row (i_wr_row),
		.i_valid  (i_valid),
		.i_rd_addr(i_rd_addr),
		.i_inputs (i_inputs),
		.o_fetch  (fetch)
	);

	// Stage 2, multiply
	product_stage i_product_stage (
		.clk    (clk),
		.rst    (rst),
		.i_fetch(fetch),
		.o_prod (prod)
	);

	// Stage 3, accumulate and saturate
	sum_stage i_sum_stage (
		.clk   (clk),
		.rst   (rst),
		.i_prod(prod),
		.o_sum (sum)
	);

	// Stage 4, activation
	sigmoid_pla i_sigmoid_pla (
		.clk    (clk),
		.rst    (rst),
		.i_sum  (sum),
		.o_valid(o_valid),
		.o_act  (o_act),
		.o_sum  (o_sum),
		.o_row  (o_row)
	);

endmodule

`default_nettype wire

// File: bench/neuron_tb.sv
// Sigmoid neuron testbench with stimulus file replay, expected result queue, checks and timeout
`default_nettype none
`timescale 1ns/1ps

`include "neuron_consts.svh"

module neuron_tb import neuron_pkg::*; ();

	// Words per stimulus line and room for the whole file
	localparam int OP_WORDS = 8;
	localparam int MAX_OPS  = 64;
	// Edges from the sampling edge of a strobe to the edge that takes its result
	localparam int LATENCY  = 4;

	// One compute in flight with the edge its result is due on
	typedef struct packed {
		logic [31:0] op;
		logic [31:0] due;
		data_t       sum;
		data_t       act;
		weight_row_t row;
	} expect_t;

	logic                      clk;
	logic                      rst;
	logic                      i_wr;
	logic [`NEURON_ADDR_W-1:0] i_wr_addr;
	weight_row_t               i_wr_row;
	logic                      i_valid;
	logic [`NEURON_ADDR_W-1:0] i_rd_addr;
	vec_t                      i_inputs;
	logic                      o_valid;
	data_t                     o_act;
	data_t                     o_sum;
	weight_row_t               o_row;

	// Stimulus words, bank model and pending write
	logic [15:0]               stim_mem [MAX_OPS*OP_WORDS];
	weight_row_t               shadow [`NEURON_ROWS];
	logic                      wr_pending;
	logic [`NEURON_ADDR_W-1:0] wr_addr_q;
	weight_row_t               wr_row_q;
	// Results still to come with the oldest first
	expect_t                   exp_q [$];
	expect_t                   head;
	logic [31:0]               cyc;
	logic [31:0]               limit;
	int                        nops;

	sigmoid_neuron i_sigmoid_neuron (
		.clk      (clk),
		.rst      (rst),
		.i_wr     (i_wr),
		.i_wr_addr(i_wr_addr),
		.i_wr_row (i_wr_row),
		.i_valid  (i_valid),
		.i_rd_addr(i_rd_addr),
		.i_inputs (i_inputs),
		.o_valid  (o_valid),
		.o_act    (o_act),
		.o_sum    (o_sum),
		.o_row    (o_row)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock and cycle limit
	//////////////////////////////////////////////////////////////////////

	// 8 ns period
	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cyc <= cyc + 32'd1;
		if (cyc >= limit)
		begin
			$display("timeout, run did not finish within %0d cycles", limit);
			$display("Finished with errors");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [79:0] expected,
		input logic [79:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "stopped at the first wrong value");
		end
	endtask

	// Reads the file and counts lines up to the end marker
	task automatic load_stimulus();
		$readmemh("bench/neuron_stim.hex", stim_mem);
		nops = 0;
		while (nops < MAX_OPS && stim_mem[nops*OP_WORDS] !== 16'h0000
			&& !$isunknown(stim_mem[nops*OP_WORDS]))
			nops++;
		// Every op gets its own edge plus up to 3 idle ones before drain and slack
		limit = nops * 4 + 4 + 50;
		if (nops == 0)
		begin
			$display("stimulus file bench/neuron_stim.hex is missing or holds no operations");
			$display("Finished with errors");
			$fatal(1, "no stimulus");
		end
	endtask

	function automatic weight_row_t row_from_stim(input int base);
		weight_row_t r;
		for (int i = 0; i < `NEURON_NUM_IN; i++)
			r.weights[i] = stim_mem[base + 2 + i];
		r.bias = stim_mem[base + 6];
		return r;
	endfunction

	function automatic vec_t vec_from_stim(input int base);
		vec_t v;
		for (int i = 0; i < `NEURON_NUM_IN; i++)
			v[i] = stim_mem[base + 2 + i];
		return v;
	endfunction

	// Bank model takes a write one edge late so a same-edge compute reads the old row
	task automatic commit_write();
		if (wr_pending)
		begin
			shadow[wr_addr_q] = wr_row_q;
			wr_pending = 1'b0;
		end
	endtask

	task automatic issue_op(input int idx);
		int                        base;
		logic [15:0]               op;
		logic [`NEURON_ADDR_W-1:0] addr;
		expect_t                   e;
		base = idx * OP_WORDS;
		op   = stim_mem[base];
		addr = stim_mem[base + 1][`NEURON_ADDR_W-1:0];
		if (op[3:0] == 4'h1)
		begin
			i_wr       <= 1'b1;
			i_wr_addr  <= addr;
			i_wr_row   <= row_from_stim(base);
			wr_pending = 1'b1;
			wr_addr_q  = addr;
			wr_row_q   = row_from_stim(base);
		end
		else if (op[3:0] == 4'h2)
		begin
			i_valid   <= 1'b1;
			i_rd_addr <= addr;
			i_inputs  <= vec_from_stim(base);
			e.op  = idx;
			// Strobe sampled on edge cyc+2 and result taken LATENCY edges later
			// The monitor sees o_valid in the half cycle before that edge
			e.due = cyc + 32'(1 + LATENCY);
			e.sum = stim_mem[base + 6];
			e.act = stim_mem[base + 7];
			e.row = shadow[addr];
			exp_q.push_back(e);
		end
		else
		begin
			$display("unknown opcode %h on stimulus operation %0d", op, idx);
			$display("Finished with errors");
			$fatal(1, "bad stimulus");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int          idx;
		int          gap;
		logic [15:0] op;
		clk        = 1'b0;
		rst        = 1'b1;
		i_wr       = 1'b0;
		i_wr_addr  = '0;
		i_wr_row   = '0;
		i_valid    = 1'b0;
		i_rd_addr  = '0;
		i_inputs   = '0;
		cyc        = '0;
		limit      = '1;
		wr_pending = 1'b0;
		wr_addr_q  = '0;
		wr_row_q   = '0;
		head       = '0;
		// Bank is all zero after reset
		for (int r = 0; r < `NEURON_ROWS; r++)
			shadow[r] = '0;
		void'($urandom(32'hcc8e82b9));
		load_stimulus();

		repeat (3) @(posedge clk);
		rst <= 1'b0;

		idx = 0;
		gap = 0;
		op  = '0;
		while (idx < nops)
		begin
			@(posedge clk);
			commit_write();
			// Strobes last one cycle unless an op below raises them again
			i_wr    <= 1'b0;
			i_valid <= 1'b0;
			if (gap > 0)
				gap--;
			else
			begin
				// Flag 2 puts the next op on this same edge
				do
				begin
					op = stim_mem[idx*OP_WORDS];
					issue_op(idx);
					idx++;
				end while (op[7:4] == 4'h2 && idx < nops);
				// Flag 1 means no idle gap before the next op
				gap = (op[7:4] == 4'h1) ? 0 : $urandom % 4;
			end
		end
		@(posedge clk);
		commit_write();
		i_wr    <= 1'b0;
		i_valid <= 1'b0;

		// Room for the last result plus a few idle cycles for a stray o_valid
		repeat (LATENCY + 4) @(negedge clk);

		if (exp_q.size() == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			$display("%0d results never arrived", exp_q.size());
			$display("Finished with errors");
			$fatal(1, "results outstanding at the end");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result monitor
	//////////////////////////////////////////////////////////////////////

	// Outputs are sampled mid-cycle away from the edge that moves them
	always @(negedge clk)
	begin
		if (o_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("o_valid high at cycle %0d with no compute outstanding", cyc);
				$display("Finished with errors");
				$fatal(1, "unexpected result");
			end
			else
			begin
				head = exp_q.pop_front();
				check_value($sformatf("op %0d latency", head.op), {48'h0, head.due},
					{48'h0, cyc});
				check_value($sformatf("op %0d sum", head.op), {64'h0, head.sum},
					{64'h0, o_sum});
				check_value($sformatf("op %0d act", head.op), {64'h0, head.act},
					{64'h0, o_act});
				check_value($sformatf("op %0d row", head.op), head.row, o_row);
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/neuron_stim.hex
// op addr d0 d1 d2 d3 bias_or_sum act, write rows carry weights d0..d3 and a bias
// op 0001 write, 0002 compute, 0011/0012 next op on the next edge, 0021 next op same edge, 0000 end
0002 0005 0100 0200 0300 0400 0000 0080
0002 0000 ffff 8000 7fff 0001 0000 0080
0001 0001 0100 0000 0000 0000 0000 0000
0001 0002 0180 ff00 0040 fe80 0020 0000
0002 0002 0100 0080 0200 0000 01a0 00d4
0002 0002 0300 0100 ff00 0080 02a0 00ed
0002 0002 0000 0000 0000 0017 fffd 0080
0002 0002 0000 0000 0000 0015 0000 0080
0001 0003 7fff 7fff 7fff 7fff 7fff 0000
0002 0003 7fff 7fff 7fff 7fff 7fff 0100
0002 0003 8000 8000 8000 8000 8000 0000
0002 0001 0500 1111 2222 3333 0500 0100
0002 0001 04ff 0000 0000 0000 04ff 00ff
0002 0001 0260 0000 0000 0000 0260 00eb
0002 0001 025f 0000 0000 0000 025f 00eb
0002 0001 0100 0000 0000 0000 0100 00c0
0002 0001 00ff 0000 0000 0000 00ff 00bf
0002 0001 0040 0000 0000 0000 0040 0090
0002 0001 fb00 0000 0000 0000 fb00 0000
0002 0001 fb01 0000 0000 0000 fb01 0001
0002 0001 fc00 0000 0000 0000 fc00 0008
0002 0001 fda0 0000 0000 0000 fda0 0015
0002 0001 fe80 0000 0000 0000 fe80 0030
0002 0001 ff00 0000 0000 0000 ff00 0040
0002 0001 ff01 0000 0000 0000 ff01 0041
0012 0002 0100 0080 0200 0000 01a0 00d4
0021 0002 0100 0000 0000 0000 0100 0000
0012 0002 0100 0080 0200 0000 01a0 00d4
0012 0002 0100 0080 0200 0000 0200 00e0
0012 0001 0300 0000 0000 0000 0300 00f0
0011 0004 ff00 0000 0000 0000 0000 0000
0002 0004 0100 0000 0000 0000 ff00 0040
0000 0000 0000 0000 0000 0000 0000 0000

// File: flist.f
+incdir+hw
hw/neuron_pkg.sv
hw/weight_bank.sv
hw/product_stage.sv
hw/sum_stage.sv
hw/sigmoid_pla.sv
hw/sigmoid_neuron.sv
bench/neuron_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the sigmoid neuron

VERILATOR ?= verilator
TOP       ?= neuron_tb
RTL_TOP   ?= sigmoid_neuron
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall
INC_DIRS  ?= +incdir+hw
RTL_SRCS  ?= hw/neuron_pkg.sv hw/weight_bank.sv hw/product_stage.sv \
             hw/sum_stage.sv hw/sigmoid_pla.sv hw/sigmoid_neuron.sv
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# The run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(INC_DIRS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
